//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := dbg_trace_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+src
src/dbg_pkg.sv
src/dbg_csr_regs.sv
src/dbg_source_mux.sv
src/dbg_lane_delay_mux.sv
src/dbg_trigger_capture.sv
src/dbg_trace_top.sv
sim/dbg_trace_checker.sv
sim/dbg_trace_tb.sv

//--- sim/dbg_trace_checker.sv
// Trigger protocol assertions

`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_trace_checker (
  input logic clock,
  input logic rst,
  input logic trig_hit,
  input logic trig_armed
);

  // A hit is a single-cycle pulse
  hit_single_pulse: assert property (
    @(posedge clock) disable iff (rst) trig_hit |=> !trig_hit
  ) else $error("trig_hit stayed high for two cycles in a row");

  // Armed flag drops together with the hit pulse
  armed_falls_on_hit: assert property (
    @(posedge clock) disable iff (rst) trig_hit |-> ($past(trig_armed) && !trig_armed)
  ) else $error("trig_armed did not fall after a trigger hit");

  // Trigger outputs are quiet coming out of reset
  quiet_after_reset: assert property (
    @(posedge clock) rst |=> (!trig_hit && !trig_armed)
  ) else $error("trigger outputs active after reset");

endmodule

//--- sim/dbg_trace_tb.sv
// Debug trace subsystem testbench

`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_trace_tb;

  localparam int DW = `DBG_DATA_WIDTH;
  localparam int LW = `DBG_LANE_WIDTH;
  localparam int NL = `DBG_NUM_LANES;
  localparam int CW = `DBG_CSR_WIDTH;
  localparam int CLOCK_PERIOD = 100;
  localparam int NUM_ROWS = 6;
  localparam int ROW_OVERHEAD = 24;

  // Test table, one entry per row in each array
  localparam logic [CW-1:0] ROW_SRC_SEL [NUM_ROWS] =
    '{16'h0000, 16'hE4E4, 16'h1B6C, 16'hFFFF, 16'h9C36, 16'h4E72};
  localparam logic [CW-1:0] ROW_DELAY_SEL [NUM_ROWS] =
    '{16'h0000, 16'h0000, 16'hE4E4, 16'h5A5A, 16'hC3C3, 16'h27D8};
  localparam logic [CW-1:0] ROW_MATCH [NUM_ROWS] =
    '{16'h0000, 16'h0001, 16'h0005, 16'h00A0, 16'h1234, 16'h0102};
  localparam logic [CW-1:0] ROW_MASK [NUM_ROWS] =
    '{16'h0000, 16'h0003, 16'h000F, 16'h00F0, 16'h0000, 16'h0303};
  localparam int ROW_CYCLES [NUM_ROWS] = '{12, 16, 24, 20, 10, 20};

  logic          clock = 1'b0;
  logic          rst = 1'b1;
  logic [DW-1:0] src0 = '0;
  logic [DW-1:0] src1 = '0;
  logic [DW-1:0] src2 = '0;
  logic [DW-1:0] src3 = '0;
  logic          csr_wr = 1'b0;
  logic          csr_rd = 1'b0;
  logic [1:0]    csr_addr = 2'd0;
  logic [CW-1:0] csr_wdata = '0;
  logic          trig_rearm = 1'b0;
  logic [DW-1:0] debug_out;
  logic [CW-1:0] csr_rdata;
  logic          trig_hit;
  logic          trig_armed;
  logic [DW-1:0] capture_data;

  logic [31:0]   lfsr_state = 32'd74150;
  int            hit_count = 0;

  // Reference model state
  dbg_pkg::csr_word_u    m_src_sel;
  dbg_pkg::csr_word_u    m_delay_sel;
  dbg_pkg::csr_word_u    m_rdata;
  logic [CW-1:0]         m_match;
  logic [CW-1:0]         m_mask;
  logic                  m_hit;
  logic                  m_armed;
  logic [DW-1:0]         m_capture;
  logic [NL-1:0][LW-1:0] lane_hist [4];

  dbg_trace_top dbg_trace_top_i (
    .clock        (clock),
    .rst          (rst),
    .src0         (src0),
    .src1         (src1),
    .src2         (src2),
    .src3         (src3),
    .csr_wr       (csr_wr),
    .csr_rd       (csr_rd),
    .csr_addr     (csr_addr),
    .csr_wdata    (csr_wdata),
    .trig_rearm   (trig_rearm),
    .debug_out    (debug_out),
    .csr_rdata    (csr_rdata),
    .trig_hit     (trig_hit),
    .trig_armed   (trig_armed),
    .capture_data (capture_data)
  );

  bind dbg_trace_top dbg_trace_checker dbg_trace_checker_i (
    .clock      (clock),
    .rst        (rst),
    .trig_hit   (trig_hit),
    .trig_armed (trig_armed)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [DW-1:0] random_word();
    logic [DW-1:0] word;
    for (int b = 0; b < DW; b++) begin
      word[b] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
    return word;
  endfunction

  function automatic logic [LW-1:0] pick_lane(input logic [1:0] sel, input int lane,
      input logic [DW-1:0] s0, input logic [DW-1:0] s1,
      input logic [DW-1:0] s2, input logic [DW-1:0] s3);
    case (sel)
      2'd1:    return s1[lane*LW +: LW];
      2'd2:    return s2[lane*LW +: LW];
      2'd3:    return s3[lane*LW +: LW];
      default: return s0[lane*LW +: LW];
    endcase
  endfunction

  // Lane i shows the selected lane from its delay count of cycles back
  function automatic logic [DW-1:0] expected_debug();
    logic [NL-1:0][LW-1:0] word;
    for (int i = 0; i < NL; i++) begin
      word[i] = lane_hist[m_delay_sel.lane[i]][i];
    end
    return word;
  endfunction

  // Every bit the mask selects must equal the pattern bit
  function automatic logic masked_match(input logic [CW-1:0] low_bits,
      input logic [CW-1:0] pattern, input logic [CW-1:0] mask);
    for (int b = 0; b < CW; b++) begin
      if (mask[b] && low_bits[b] != pattern[b]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  function automatic logic [CW-1:0] model_reg(input logic [1:0] addr);
    case (addr)
      `DBG_ADDR_SRC_SEL:    return m_src_sel.raw;
      `DBG_ADDR_DELAY_SEL:  return m_delay_sel.raw;
      `DBG_ADDR_TRIG_MATCH: return m_match;
      default:              return m_mask;
    endcase
  endfunction

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input logic [DW-1:0] got,
      input logic [DW-1:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_csr(input string name, input dbg_pkg::csr_word_u got,
      input dbg_pkg::csr_word_u exp);
    if (got.raw !== exp.raw) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got.raw, exp.raw);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [CW-1:0] data);
    @(posedge clock);
    csr_wr    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
  endtask

  // Read strobe, then check the data one cycle later
  task automatic read_reg(input logic [1:0] addr, input logic [CW-1:0] exp);
    @(posedge clock);
    csr_rd   <= 1'b1;
    csr_addr <= addr;
    @(posedge clock);
    csr_rd   <= 1'b0;
    @(negedge clock);
    check_csr("csr_rdata", csr_rdata, exp);
  endtask

  // Fresh source words every cycle
  always @(posedge clock) begin
    src0 <= random_word();
    src1 <= random_word();
    src2 <= random_word();
    src3 <= random_word();
  end

  // Reference model, stepped on the same edge as the DUT
  always @(posedge clock) begin : model_step
    logic [DW-1:0] seen;
    logic          hit_now;
    if (rst) begin
      m_src_sel.raw   = '0;
      m_delay_sel.raw = '0;
      m_rdata.raw     = '0;
      m_match         = '0;
      m_mask          = '0;
      m_hit           = 1'b0;
      m_armed         = 1'b0;
      m_capture       = '0;
      for (int h = 0; h < 4; h++) begin
        lane_hist[h] = '0;
      end
    end else begin
      seen    = expected_debug();
      hit_now = m_armed && masked_match(seen[CW-1:0], m_match, m_mask) && !trig_rearm;
      m_hit   = hit_now;
      if (trig_rearm) begin
        m_armed = 1'b1;
      end else if (hit_now) begin
        m_armed = 1'b0;
      end
      if (hit_now) begin
        m_capture = seen;
      end
      for (int h = 3; h > 0; h--) begin
        lane_hist[h] = lane_hist[h - 1];
      end
      for (int i = 0; i < NL; i++) begin
        lane_hist[0][i] = pick_lane(m_src_sel.lane[i], i, src0, src1, src2, src3);
      end
      if (csr_rd) begin
        m_rdata.raw = model_reg(csr_addr);
      end
      if (csr_wr) begin
        case (csr_addr)
          `DBG_ADDR_SRC_SEL:    m_src_sel.raw = csr_wdata;
          `DBG_ADDR_DELAY_SEL:  m_delay_sel.raw = csr_wdata;
          `DBG_ADDR_TRIG_MATCH: m_match = csr_wdata;
          default:              m_mask = csr_wdata;
        endcase
      end
    end
  end

  // Outputs are settled by the falling edge
  always @(negedge clock) begin
    check_word("debug_out", debug_out, expected_debug());
    check_word("capture_data", capture_data, m_capture);
    check_bit("trig_hit", trig_hit, m_hit);
    check_bit("trig_armed", trig_armed, m_armed);
    check_csr("csr_rdata", csr_rdata, m_rdata);
    if (trig_hit) begin
      hit_count++;
    end
  end

  initial begin : main_sequence
    int hits_before;
    repeat (10) @(posedge clock);
    rst <= 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      write_reg(`DBG_ADDR_SRC_SEL, ROW_SRC_SEL[r]);
      write_reg(`DBG_ADDR_DELAY_SEL, ROW_DELAY_SEL[r]);
      write_reg(`DBG_ADDR_TRIG_MATCH, ROW_MATCH[r]);
      write_reg(`DBG_ADDR_TRIG_MASK, ROW_MASK[r]);
      @(posedge clock);
      csr_wr <= 1'b0;
      read_reg(`DBG_ADDR_SRC_SEL, ROW_SRC_SEL[r]);
      read_reg(`DBG_ADDR_DELAY_SEL, ROW_DELAY_SEL[r]);
      read_reg(`DBG_ADDR_TRIG_MATCH, ROW_MATCH[r]);
      read_reg(`DBG_ADDR_TRIG_MASK, ROW_MASK[r]);
      hits_before = hit_count;
      @(posedge clock);
      trig_rearm <= 1'b1;
      @(posedge clock);
      trig_rearm <= 1'b0;
      repeat (ROW_CYCLES[r]) @(posedge clock);
      // An empty mask matches every word
      if (ROW_MASK[r] == '0 && hit_count == hits_before) begin
        $display("** Error at %0t: no trigger hit after rearm in row %0d", $time, r);
        stop_with_failure();
      end
    end
    $display("Done: no errors");
    $finish;
  end

  initial begin : watchdog
    int budget;
    budget = 10 + 40;
    for (int r = 0; r < NUM_ROWS; r++) begin
      budget += ROW_CYCLES[r] + ROW_OVERHEAD;
    end
    #(budget * CLOCK_PERIOD);
    $display("Watchdog expired at %0t before the test table finished", $time);
    $display("Done: errors found");
    $fatal(1, "watchdog timeout");
  end

endmodule

//--- src/dbg_csr_regs.sv
// Debug trace control registers

`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_csr_regs (
  input  logic                      clock,
  input  logic                      rst,
  input  logic                      csr_wr,
  input  logic                      csr_rd,
  input  logic [1:0]                csr_addr,
  input  logic [`DBG_CSR_WIDTH-1:0] csr_wdata,
  output logic [`DBG_CSR_WIDTH-1:0] csr_rdata,
  output dbg_pkg::csr_word_u        src_sel,
  output dbg_pkg::csr_word_u        delay_sel,
  output logic [`DBG_CSR_WIDTH-1:0] trig_match,
  output logic [`DBG_CSR_WIDTH-1:0] trig_mask
);

  dbg_pkg::csr_word_u rd_word;

  // Register writes, visible to the datapath from the next cycle
  always_ff @(posedge clock) begin
    if (rst) begin
      src_sel.raw   <= '0;
      delay_sel.raw <= '0;
      trig_match    <= '0;
      trig_mask     <= '0;
    end else if (csr_wr) begin
      case (csr_addr)
        `DBG_ADDR_SRC_SEL:    src_sel.raw   <= csr_wdata;
        `DBG_ADDR_DELAY_SEL:  delay_sel.raw <= csr_wdata;
        `DBG_ADDR_TRIG_MATCH: trig_match    <= csr_wdata;
        default:              trig_mask     <= csr_wdata;
      endcase
    end
  end

  // Read select
  always_comb begin
    case (csr_addr)
      `DBG_ADDR_SRC_SEL:    rd_word = src_sel;
      `DBG_ADDR_DELAY_SEL:  rd_word = delay_sel;
      `DBG_ADDR_TRIG_MATCH: rd_word.raw = trig_match;
      default:              rd_word.raw = trig_mask;
    endcase
  end

  // Read data holds until the next read strobe
  always_ff @(posedge clock) begin
    if (rst) begin
      csr_rdata <= '0;
    end else if (csr_rd) begin
      csr_rdata <= rd_word.raw;
    end
  end

endmodule

//--- src/dbg_lane_delay_mux.sv
// Per-lane delay alignment

`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_lane_delay_mux (
  input  logic                       clock,
  input  logic                       rst,
  input  logic [`DBG_DATA_WIDTH-1:0] lane_data,
  input  dbg_pkg::csr_word_u         delay_sel,
  output logic [`DBG_DATA_WIDTH-1:0] debug_out
);

  logic [`DBG_NUM_LANES-1:0][`DBG_LANE_WIDTH-1:0] lane_live;
  logic [`DBG_NUM_LANES-1:0][`DBG_LANE_WIDTH-1:0] lane_d1;
  logic [`DBG_NUM_LANES-1:0][`DBG_LANE_WIDTH-1:0] lane_d2;
  logic [`DBG_NUM_LANES-1:0][`DBG_LANE_WIDTH-1:0] lane_d3;
  logic [`DBG_NUM_LANES-1:0][`DBG_LANE_WIDTH-1:0] lane_out;

  assign lane_live = lane_data;

  // Three-stage history per lane, all lanes shift together
  always_ff @(posedge clock) begin
    if (rst) begin
      lane_d1 <= '0;
      lane_d2 <= '0;
      lane_d3 <= '0;
    end else begin
      lane_d1 <= lane_live;
      lane_d2 <= lane_d1;
      lane_d3 <= lane_d2;
    end
  end

  // Age select, zero passes the live lane straight through
  always_comb begin
    for (int i = 0; i < `DBG_NUM_LANES; i++) begin
      case (delay_sel.lane[i])
        2'd3:    lane_out[i] = lane_d3[i];
        2'd2:    lane_out[i] = lane_d2[i];
        2'd1:    lane_out[i] = lane_d1[i];
        default: lane_out[i] = lane_live[i];
      endcase
    end
  end

  assign debug_out = lane_out;

endmodule

//--- src/dbg_pkg.sv
// Debug trace shared types

`include "dbg_settings.svh"

package dbg_pkg;

  // One control word, seen either as a plain value or as per-lane selects.
  // Under the lane view each lane owns two bits, lane i at bits 2i+1:2i.
  // The source select and delay select registers both use the lane view,
  // the pattern and mask registers use the raw view.
  typedef union packed {
    logic [`DBG_CSR_WIDTH-1:0]          raw;
    logic [`DBG_NUM_LANES-1:0][1:0]     lane;
  } csr_word_u;

endpackage

//--- src/dbg_settings.svh
// Debug trace subsystem settings

`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

// Lane geometry
`define DBG_LANE_WIDTH 8
`define DBG_NUM_LANES 8
`define DBG_DATA_WIDTH (`DBG_LANE_WIDTH * `DBG_NUM_LANES)

// Control register file
`define DBG_CSR_WIDTH 16
`define DBG_ADDR_SRC_SEL 2'd0
`define DBG_ADDR_DELAY_SEL 2'd1
`define DBG_ADDR_TRIG_MATCH 2'd2
`define DBG_ADDR_TRIG_MASK 2'd3

`endif

//--- src/dbg_source_mux.sv
// Per-lane debug source selection

`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_source_mux (
  input  logic                       clock,
  input  logic                       rst,
  input  logic [`DBG_DATA_WIDTH-1:0] src0,
  input  logic [`DBG_DATA_WIDTH-1:0] src1,
  input  logic [`DBG_DATA_WIDTH-1:0] src2,
  input  logic [`DBG_DATA_WIDTH-1:0] src3,
  input  dbg_pkg::csr_word_u         src_sel,
  output logic [`DBG_DATA_WIDTH-1:0] lane_data
);

  logic [`DBG_NUM_LANES-1:0][`DBG_LANE_WIDTH-1:0] lane_next;

  // Each lane picks the same lane position from its own source bus
  always_comb begin
    for (int i = 0; i < `DBG_NUM_LANES; i++) begin
      case (src_sel.lane[i])
        2'd3: begin
          lane_next[i] = src3[i*`DBG_LANE_WIDTH +: `DBG_LANE_WIDTH];
        end
        2'd2: begin
          lane_next[i] = src2[i*`DBG_LANE_WIDTH +: `DBG_LANE_WIDTH];
        end
        2'd1: begin
          lane_next[i] = src1[i*`DBG_LANE_WIDTH +: `DBG_LANE_WIDTH];
        end
        default: begin
          lane_next[i] = src0[i*`DBG_LANE_WIDTH +: `DBG_LANE_WIDTH];
        end
      endcase
    end
  end

  // One register stage after the select
  always_ff @(posedge clock) begin
    if (rst) begin
      lane_data <= '0;
    end else begin
      lane_data <= lane_next;
    end
  end

endmodule

//--- src/dbg_trace_top.sv
// Debug trace subsystem top level

`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_trace_top (
  input  logic                       clock,
  input  logic                       rst,
  input  logic [`DBG_DATA_WIDTH-1:0] src0,
  input  logic [`DBG_DATA_WIDTH-1:0] src1,
  input  logic [`DBG_DATA_WIDTH-1:0] src2,
  input  logic [`DBG_DATA_WIDTH-1:0] src3,
  input  logic                       csr_wr,
  input  logic                       csr_rd,
  input  logic [1:0]                 csr_addr,
  input  logic [`DBG_CSR_WIDTH-1:0]  csr_wdata,
  input  logic                       trig_rearm,
  output logic [`DBG_DATA_WIDTH-1:0] debug_out,
  output logic [`DBG_CSR_WIDTH-1:0]  csr_rdata,
  output logic                       trig_hit,
  output logic                       trig_armed,
  output logic [`DBG_DATA_WIDTH-1:0] capture_data
);

  dbg_pkg::csr_word_u               src_sel;
  dbg_pkg::csr_word_u               delay_sel;
  logic [`DBG_CSR_WIDTH-1:0]        trig_match;
  logic [`DBG_CSR_WIDTH-1:0]        trig_mask;
  logic [`DBG_DATA_WIDTH-1:0]       lane_data;

  dbg_csr_regs dbg_csr_regs_i (
    .clock      (clock),
    .rst        (rst),
    .csr_wr     (csr_wr),
    .csr_rd     (csr_rd),
    .csr_addr   (csr_addr),
    .csr_wdata  (csr_wdata),
    .csr_rdata  (csr_rdata),
    .src_sel    (src_sel),
    .delay_sel  (delay_sel),
    .trig_match (trig_match),
    .trig_mask  (trig_mask)
  );

  dbg_source_mux dbg_source_mux_i (
    .clock     (clock),
    .rst       (rst),
    .src0      (src0),
    .src1      (src1),
    .src2      (src2),
    .src3      (src3),
    .src_sel   (src_sel),
    .lane_data (lane_data)
  );

  // Aligned word feeds both the output and the trigger
  dbg_lane_delay_mux dbg_lane_delay_mux_i (
    .clock     (clock),
    .rst       (rst),
    .lane_data (lane_data),
    .delay_sel (delay_sel),
    .debug_out (debug_out)
  );

  dbg_trigger_capture dbg_trigger_capture_i (
    .clock        (clock),
    .rst          (rst),
    .debug_out    (debug_out),
    .trig_match   (trig_match),
    .trig_mask    (trig_mask),
    .trig_rearm   (trig_rearm),
    .trig_hit     (trig_hit),
    .trig_armed   (trig_armed),
    .capture_data (capture_data)
  );

endmodule

//--- src/dbg_trigger_capture.sv
// Masked pattern trigger with one-shot capture

`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_trigger_capture (
  input  logic                       clock,
  input  logic                       rst,
  input  logic [`DBG_DATA_WIDTH-1:0] debug_out,
  input  logic [`DBG_CSR_WIDTH-1:0]  trig_match,
  input  logic [`DBG_CSR_WIDTH-1:0]  trig_mask,
  input  logic                       trig_rearm,
  output logic                       trig_hit,
  output logic                       trig_armed,
  output logic [`DBG_DATA_WIDTH-1:0] capture_data
);

  dbg_pkg::csr_word_u miss_bits;
  logic               pattern_match;
  logic               take_hit;

  // Bits that differ from the pattern, counted only where the mask is set
  assign miss_bits.raw = (debug_out[`DBG_CSR_WIDTH-1:0] ^ trig_match) & trig_mask;
  assign pattern_match = (miss_bits.raw == '0);

  // A rearm in the same cycle takes priority over a match
  assign take_hit = trig_armed && pattern_match && !trig_rearm;

  // Armed flag and hit pulse
  always_ff @(posedge clock) begin
    if (rst) begin
      trig_armed <= 1'b0;
      trig_hit   <= 1'b0;
    end else begin
      trig_hit <= take_hit;
      if (trig_rearm) begin
        trig_armed <= 1'b1;
      end else if (take_hit) begin
        trig_armed <= 1'b0;
      end
    end
  end

  // Captured word stays put until the next hit
  always_ff @(posedge clock) begin
    if (rst) begin
      capture_data <= '0;
    end else if (take_hit) begin
      capture_data <= debug_out;
    end
  end

endmodule
